//--- src.f
logic/xb_pkg.sv
logic/xb_stream_if.sv
logic/small_fifo.sv
logic/pkt_gate.sv
logic/route_table.sv
logic/ingress_buff.sv
logic/xb_ingress_top.sv
tests/xb_ingress_assert.sv
tests/xb_ingress_tb.sv

//--- tests/xb_ingress_tb.sv
// ----------------------------------------
// Testbench for the crossbar ingress port
// ----------------------------------------
`timescale 1ns/1ps

module xb_ingress_tb;

  import xb_pkg::*;

  // One stimulus row; a config row writes the routing table instead of sending
  typedef struct {
    string  name;
    logic   cfg;
    route_e code;
    port_t  dest;
    epid_t  epid;
    int     len;
    logic   stall;
  } row_t;

  // One expected output word with the destination its packet must carry
  typedef struct {
    word_t data;
    logic  last;
    port_t port;
    logic  keep;
    int    row;
  } beat_t;

  localparam int N_ROWS = 16;

  logic   clk;
  logic   reset;
  word_t  i_tdata;
  port_t  i_tdest;
  route_e i_tid;
  logic   i_tlast;
  logic   i_tvalid;
  logic   o_tready;
  word_t  o_tdata;
  port_t  o_tdest;
  logic   o_tkeep;
  logic   o_tlast;
  logic   o_tvalid;
  logic   i_tready;
  logic   i_cfg_valid;
  epid_t  i_cfg_epid;
  port_t  i_cfg_port;

  row_t   table_rows [N_ROWS];
  beat_t  exp_q [$];
  port_t  route_map [epid_t];
  beat_t  head;
  int     in_done;
  int     out_done;
  int     n_pkts;
  int     total_words;
  logic   bp_on;

  xb_ingress_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic add_row(input int idx, input string name, input logic cfg,
                         input route_e code, input port_t dest, input epid_t epid,
                         input int len, input logic stall);
    table_rows[idx].name  = name;
    table_rows[idx].cfg   = cfg;
    table_rows[idx].code  = code;
    table_rows[idx].dest  = dest;
    table_rows[idx].epid  = epid;
    table_rows[idx].len   = len;
    table_rows[idx].stall = stall;
  endtask

  task automatic fill_table();
    add_row(0,  "tdest_p2",     0, ROUTE_TDEST,    2'd2, 16'h0000, 4,  0);
    add_row(1,  "tdest_single", 0, ROUTE_TDEST,    2'd3, 16'h0000, 1,  0);
    add_row(2,  "return_src",   0, RETURN_TO_SRC,  2'd3, 16'h0000, 3,  0);
    add_row(3,  "cfg_a",        1, ROUTE_EPID,     2'd2, 16'h1234, 0,  0);
    add_row(4,  "cfg_b",        1, ROUTE_EPID,     2'd3, 16'h00a5, 0,  0);
    add_row(5,  "epid_hit_a",   0, ROUTE_EPID,     2'd0, 16'h1234, 5,  0);
    add_row(6,  "epid_hit_b",   0, ROUTE_EPID,     2'd1, 16'h00a5, 2,  0);
    add_row(7,  "epid_miss",    0, ROUTE_EPID,     2'd2, 16'h7777, 4,  0);
    add_row(8,  "cfg_rewrite",  1, ROUTE_EPID,     2'd0, 16'h1234, 0,  0);
    add_row(9,  "epid_rewrite", 0, ROUTE_EPID,     2'd3, 16'h1234, 3,  0);
    add_row(10, "mix_epid",     0, ROUTE_EPID,     2'd0, 16'h00a5, 6,  1);
    add_row(11, "mix_return",   0, RETURN_TO_SRC,  2'd0, 16'h0000, 2,  1);
    add_row(12, "mix_miss",     0, ROUTE_EPID,     2'd1, 16'h0bad, 3,  1);
    add_row(13, "mix_code3",    0, route_e'(2'b11), 2'd2, 16'h0000, 4, 1);
    add_row(14, "mix_max",      0, ROUTE_EPID,     2'd3, 16'h1234, 32, 1);
    add_row(15, "mix_tdest",    0, ROUTE_TDEST,    2'd1, 16'h0000, 1,  1);
  endtask

  // Expected destination from the routing rules and the configured table
  task automatic predict_dest(input row_t r, output port_t port, output logic keep);
    port = r.dest;
    keep = 1'b1;
    if (r.code == RETURN_TO_SRC) begin
      port = port_t'(NODE_ID);
    end else if (r.code == ROUTE_EPID) begin
      keep = route_map.exists(r.epid);
      port = '0;
      if (keep) begin
        port = route_map[r.epid];
      end
    end
  endtask

  // Called at a falling edge and returns at a falling edge
  task automatic write_config(input epid_t epid, input port_t port);
    i_cfg_epid  = epid;
    i_cfg_port  = port;
    i_cfg_valid = 1'b1;
    @(negedge clk);
    i_cfg_valid = 1'b0;
    route_map[epid] = port;
  endtask

  task automatic send_packet(input int idx);
    row_t  r;
    beat_t b;
    port_t port;
    logic  keep;
    word_t data;
    int    w;
    r = table_rows[idx];
    predict_dest(r, port, keep);
    bp_on = r.stall;
    for (w = 0; w < r.len; w++) begin
      data = {$urandom(), $urandom()};
      if ((w == 0) && (r.code == ROUTE_EPID)) begin
        data[EPID_W-1:0] = r.epid;
      end
      b.data = data;
      b.last = (w == r.len - 1);
      b.port = port;
      b.keep = keep;
      b.row  = idx;
      exp_q.push_back(b);
      if (r.stall) begin
        repeat ($urandom_range(3, 0)) @(negedge clk);
      end
      i_tdata  = data;
      i_tdest  = r.dest;
      i_tid    = r.code;
      i_tlast  = b.last;
      i_tvalid = 1'b1;
      // Hold the word until the DUT takes it
      do @(posedge clk); while (!o_tready);
      @(negedge clk);
      i_tvalid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Output ready follows the stall flag of the row being sent
  task automatic drive_out_ready();
    forever begin
      @(negedge clk);
      i_tready = bp_on ? (($urandom() % 4) != 0) : 1'b1;
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("Error: the run hung, the DUT made no full progress in %0d cycles", cycles);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired");
  endtask

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------

  // Output words are compared against the queue; the input last-word count is
  // updated after the check, so a word released in the same cycle counts as early
  always @(posedge clk) begin
    if (!reset && o_tvalid && i_tready) begin
      if (exp_q.size() == 0) begin
        $display("Error: an output word appeared with no packet expected");
        $display("TESTS FAILED");
        $fatal(1, "Unexpected output");
      end else begin
        head = exp_q.pop_front();
        check_value({table_rows[head.row].name, " store-and-forward"}, 64'd1,
                    (in_done > out_done) ? 64'd1 : 64'd0);
        check_value({table_rows[head.row].name, " data"}, head.data, o_tdata);
        check_value({table_rows[head.row].name, " last"}, 64'(head.last), 64'(o_tlast));
        check_value({table_rows[head.row].name, " keep"}, 64'(head.keep), 64'(o_tkeep));
        if (head.keep) begin
          check_value({table_rows[head.row].name, " port"}, 64'(head.port), 64'(o_tdest));
        end
        if (o_tlast) begin
          out_done = out_done + 1;
        end
      end
    end
    if (!reset && i_tvalid && o_tready && i_tlast) begin
      in_done = in_done + 1;
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    void'($urandom(79319));
    reset       = 1'b1;
    i_tdata     = '0;
    i_tdest     = '0;
    i_tid       = ROUTE_TDEST;
    i_tlast     = 1'b0;
    i_tvalid    = 1'b0;
    i_tready    = 1'b0;
    i_cfg_valid = 1'b0;
    i_cfg_epid  = '0;
    i_cfg_port  = '0;
    bp_on       = 1'b0;
    in_done     = 0;
    out_done    = 0;
    n_pkts      = 0;
    total_words = 0;
    fill_table();
    for (int i = 0; i < N_ROWS; i++) begin
      if (!table_rows[i].cfg) begin
        n_pkts      = n_pkts + 1;
        total_words = total_words + table_rows[i].len;
      end
    end
    fork
      watchdog(total_words * 20 + 200);
      drive_out_ready();
    join_none
    repeat (3) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < N_ROWS; i++) begin
      // Table writes land only between packets so predictions stay exact
      if (table_rows[i].cfg) begin
        wait_drain();
        write_config(table_rows[i].epid, table_rows[i].dest);
      end else begin
        send_packet(i);
      end
    end
    wait_drain();
    repeat (8) @(negedge clk);
    // A drained port offers nothing and is ready for the next header
    if ((out_done != n_pkts) || o_tvalid || !o_tready) begin
      $display("Error: the DUT is not idle at the end, %0d of %0d packets left it",
               out_done, n_pkts);
      $display("TESTS FAILED");
      $fatal(1, "DUT not idle");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- tests/xb_ingress_assert.sv
// ----------------------------------------
// Stream protocol checks for the ingress top
// ----------------------------------------
`timescale 1ns/1ps

module xb_ingress_assert (
  input logic           clk,
  input logic           reset,
  input xb_pkg::word_t  i_tdata,
  input xb_pkg::port_t  i_tdest,
  input xb_pkg::route_e i_tid,
  input logic           i_tlast,
  input logic           i_tvalid,
  input logic           o_tready,
  input xb_pkg::word_t  o_tdata,
  input xb_pkg::port_t  o_tdest,
  input logic           o_tkeep,
  input logic           o_tlast,
  input logic           o_tvalid,
  input logic           i_tready
);

  // A raised input valid holds with the same word until the DUT takes it
  a_in_hold: assert property (@(posedge clk) disable iff (reset)
    i_tvalid && !o_tready |=> i_tvalid && $stable(i_tdata) && $stable(i_tlast)
      && $stable(i_tid) && $stable(i_tdest))
    else $error("Input valid dropped or its word changed before the transfer");

  // Same rule on the output side of the DUT
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast)
      && $stable(o_tdest) && $stable(o_tkeep))
    else $error("Output valid dropped or its word changed before the transfer");

  // The destination record stays put until the last word of its packet leaves
  a_dest_stable: assert property (@(posedge clk) disable iff (reset)
    o_tvalid && i_tready && !o_tlast |=> $stable(o_tdest) && $stable(o_tkeep))
    else $error("Output port or keep changed inside a packet");

  // Nothing is offered while the port is held in reset
  a_reset_quiet: assert property (@(posedge clk) reset |=> !o_tvalid)
    else $error("Output valid was high during reset");

endmodule

bind xb_ingress_top xb_ingress_assert u_assert (.*);

//--- logic/xb_ingress_top.sv
// ----------------------------------------
// Crossbar ingress port with its endpoint
// routing table
// ----------------------------------------
`timescale 1ns/1ps

module xb_ingress_top (
  input  logic           clk,
  input  logic           reset,
  // Packet input
  input  xb_pkg::word_t  i_tdata,
  input  xb_pkg::port_t  i_tdest,
  input  xb_pkg::route_e i_tid,
  input  logic           i_tlast,
  input  logic           i_tvalid,
  output logic           o_tready,
  // Packet output with destination and keep
  output xb_pkg::word_t  o_tdata,
  output xb_pkg::port_t  o_tdest,
  output logic           o_tkeep,
  output logic           o_tlast,
  output logic           o_tvalid,
  input  logic           i_tready,
  // Routing table configuration
  input  logic           i_cfg_valid,
  input  xb_pkg::epid_t  i_cfg_epid,
  input  xb_pkg::port_t  i_cfg_port
);

  import xb_pkg::*;

  // Lookup request and result streams between the buffer and the table
  xb_stream_if #(.T(epid_t))     find_if   ();
  xb_stream_if #(.T(dest_rec_t)) result_if ();

  ingress_buff u_ingress (
    .clk      (clk),
    .reset    (reset),
    .i_tdata  (i_tdata),
    .i_tdest  (i_tdest),
    .i_tid    (i_tid),
    .i_tlast  (i_tlast),
    .i_tvalid (i_tvalid),
    .o_tready (o_tready),
    .o_tdata  (o_tdata),
    .o_tdest  (o_tdest),
    .o_tkeep  (o_tkeep),
    .o_tlast  (o_tlast),
    .o_tvalid (o_tvalid),
    .i_tready (i_tready),
    .o_find   (find_if),
    .i_result (result_if)
  );

  route_table u_table (
    .clk         (clk),
    .reset       (reset),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_epid  (i_cfg_epid),
    .i_cfg_port  (i_cfg_port),
    .i_find      (find_if),
    .o_result    (result_if)
  );

endmodule

//--- logic/ingress_buff.sv
// ----------------------------------------
// Crossbar ingress buffer that gates each
// packet and works out its output port
// ----------------------------------------
`timescale 1ns/1ps

module ingress_buff (
  input  logic           clk,
  input  logic           reset,
  // Packet input
  input  xb_pkg::word_t  i_tdata,
  input  xb_pkg::port_t  i_tdest,
  input  xb_pkg::route_e i_tid,
  input  logic           i_tlast,
  input  logic           i_tvalid,
  output logic           o_tready,
  // Packet output toward the fabric
  output xb_pkg::word_t  o_tdata,
  output xb_pkg::port_t  o_tdest,
  output logic           o_tkeep,
  output logic           o_tlast,
  output logic           o_tvalid,
  input  logic           i_tready,
  // Lookup requests and results to and from the routing table
  xb_stream_if.src       o_find,
  xb_stream_if.snk       i_result
);

  import xb_pkg::*;

  xb_stream_if #(.T(pkt_beat_t)) gate_in  ();
  xb_stream_if #(.T(pkt_beat_t)) gate_out ();
  xb_stream_if #(.T(epid_t))     find_in  ();
  xb_stream_if #(.T(dest_rec_t)) dest_in  ();
  xb_stream_if #(.T(dest_rec_t)) dest_out ();

  // High while the next input word is the header of a new packet
  logic      hdr;
  // High from an endpoint lookup request until its answer is queued
  logic      pending;
  logic      path_ready;
  logic      hdr_stb;
  logic      is_epid;
  dest_rec_t direct_rec;

  // ----------------------------------------
  // Packet gate and FIFOs
  // ----------------------------------------

  pkt_gate u_gate (.clk(clk), .reset(reset), .i_in(gate_in), .o_out(gate_out));

  small_fifo #(.T(epid_t), .DEPTH(2)) u_find_fifo (
    .clk(clk), .reset(reset), .i_in(find_in), .o_out(o_find)
  );

  small_fifo #(.T(dest_rec_t), .DEPTH(2)) u_dest_fifo (
    .clk(clk), .reset(reset), .i_in(dest_in), .o_out(dest_out)
  );

  // ----------------------------------------
  // Input side
  // ----------------------------------------

  assign is_epid = (i_tid == ROUTE_EPID);

  // A header needs room on its destination path, and it also waits out an
  // open lookup so that destination records stay in packet order
  always_comb begin
    if (!hdr) begin
      path_ready = 1'b1;
    end else if (pending) begin
      path_ready = 1'b0;
    end else begin
      path_ready = is_epid ? find_in.ready : dest_in.ready;
    end
  end

  assign o_tready = gate_in.ready && path_ready;
  assign hdr_stb  = i_tvalid && o_tready && hdr;

  always_ff @(posedge clk) begin
    if (reset) begin
      hdr     <= 1'b1;
      pending <= 1'b0;
    end else begin
      if (i_tvalid && o_tready) begin
        hdr <= i_tlast;
      end
      // Set and clear never meet, since no header passes while pending
      if (hdr_stb && is_epid) begin
        pending <= 1'b1;
      end else if (i_result.valid && i_result.ready) begin
        pending <= 1'b0;
      end
    end
  end

  assign gate_in.valid   = i_tvalid && o_tready;
  assign gate_in.payload = '{data: i_tdata, last: i_tlast};

  assign find_in.valid   = hdr_stb && is_epid;
  assign find_in.payload = i_tdata[EPID_W-1:0];

  // Direct destinations always keep the packet
  assign direct_rec.port = (i_tid == RETURN_TO_SRC) ? port_t'(NODE_ID) : i_tdest;
  assign direct_rec.keep = 1'b1;

  // The record queue is fed by the lookup result while one is open,
  // otherwise by the header of a directly routed packet
  assign i_result.ready  = pending && dest_in.ready;
  assign dest_in.valid   = pending ? i_result.valid : (hdr_stb && !is_epid);
  assign dest_in.payload = pending ? i_result.payload : direct_rec;

  // ----------------------------------------
  // Output side
  // ----------------------------------------

  // A word goes out only with a destination beside it; the record is held
  // until the last word leaves, so tdest and tkeep cover the whole packet
  assign o_tvalid       = gate_out.valid && dest_out.valid;
  assign o_tdata        = gate_out.payload.data;
  assign o_tlast        = gate_out.payload.last;
  assign o_tdest        = dest_out.payload.port;
  assign o_tkeep        = dest_out.payload.keep;
  assign gate_out.ready = o_tvalid && i_tready;
  assign dest_out.ready = o_tvalid && i_tready && o_tlast;

endmodule

//--- logic/route_table.sv
// ----------------------------------------
// Endpoint-ID to output port routing table
// with a configuration write port
// ----------------------------------------
`timescale 1ns/1ps

module route_table (
  input  logic          clk,
  input  logic          reset,
  // Configuration writes carry no back-pressure
  input  logic          i_cfg_valid,
  input  xb_pkg::epid_t i_cfg_epid,
  input  xb_pkg::port_t i_cfg_port,
  // Lookup request and response streams
  xb_stream_if.snk      i_find,
  xb_stream_if.src      o_result
);

  import xb_pkg::*;

  // ----------------------------------------
  // Table storage
  // ----------------------------------------

  logic [RT_ENTRIES-1:0]         ent_valid;
  epid_t                         ent_epid [RT_ENTRIES];
  port_t                         ent_port [RT_ENTRIES];

  // Configuration search results
  logic                          cfg_hit;
  logic                          cfg_free;
  logic [$clog2(RT_ENTRIES)-1:0] cfg_hit_idx;
  logic [$clog2(RT_ENTRIES)-1:0] cfg_free_idx;
  logic [$clog2(RT_ENTRIES)-1:0] wr_idx;
  logic                          wr_en;

  // Lookup match and registered answer
  logic                          find_hit;
  port_t                         find_port;
  logic                          res_valid;
  dest_rec_t                     res_rec;

  // Scan from the top down so that the lowest free entry is the one kept
  // An ID is stored at most once, so at most one entry can match it
  always_comb begin
    cfg_hit      = 1'b0;
    cfg_free     = 1'b0;
    cfg_hit_idx  = '0;
    cfg_free_idx = '0;
    for (int i = RT_ENTRIES-1; i >= 0; i--) begin
      if (ent_valid[i] && (ent_epid[i] == i_cfg_epid)) begin
        cfg_hit     = 1'b1;
        cfg_hit_idx = $bits(cfg_hit_idx)'(i);
      end
      if (!ent_valid[i]) begin
        cfg_free     = 1'b1;
        cfg_free_idx = $bits(cfg_free_idx)'(i);
      end
    end
  end

  // A known ID is overwritten in place, a new one takes a free slot,
  // and a new ID arriving at a full table is dropped
  assign wr_en  = i_cfg_valid && (cfg_hit || cfg_free);
  assign wr_idx = cfg_hit ? cfg_hit_idx : cfg_free_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      ent_valid <= '0;
    end else if (wr_en) begin
      ent_valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      ent_epid[wr_idx] <= i_cfg_epid;
      ent_port[wr_idx] <= i_cfg_port;
    end
  end

  // ----------------------------------------
  // Lookup
  // ----------------------------------------

  // All entries are compared in parallel; a miss reports port zero
  always_comb begin
    find_hit  = 1'b0;
    find_port = '0;
    for (int i = 0; i < RT_ENTRIES; i++) begin
      if (ent_valid[i] && (ent_epid[i] == i_find.payload)) begin
        find_hit  = 1'b1;
        find_port = ent_port[i];
      end
    end
  end

  // One answer is held at a time and a new request waits for it to leave
  assign i_find.ready = !res_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else if (i_find.valid && i_find.ready) begin
      res_valid <= 1'b1;
    end else if (o_result.ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_find.valid && i_find.ready) begin
      res_rec.port <= find_port;
      res_rec.keep <= find_hit;
    end
  end

  assign o_result.valid   = res_valid;
  assign o_result.payload = res_rec;

endmodule

//--- logic/pkt_gate.sv
// ----------------------------------------
// Store-and-forward packet buffer that lets
// a packet out only once it is complete
// ----------------------------------------
`timescale 1ns/1ps

module pkt_gate (
  input  logic       clk,
  input  logic       reset,
  xb_stream_if.snk   i_in,
  xb_stream_if.src   o_out
);

  import xb_pkg::*;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // Word memory with one extra pointer bit to tell full from empty
  pkt_beat_t           mem [2**MTU_LOG2];
  logic [MTU_LOG2:0]   wr_ptr;
  logic [MTU_LOG2:0]   rd_ptr;

  // Number of complete packets held in the memory
  // A buffer full of one-word packets needs the full MTU_LOG2+1 bits
  logic [MTU_LOG2:0]   pkt_cnt;

  logic                full;
  logic                wr_en;
  logic                rd_en;
  logic                wr_last;
  logic                rd_last;

  // Full when the pointers match in their low bits but differ in the wrap bit
  assign full = (wr_ptr[MTU_LOG2] != rd_ptr[MTU_LOG2]) &&
                (wr_ptr[MTU_LOG2-1:0] == rd_ptr[MTU_LOG2-1:0]);

  // ----------------------------------------
  // Write side
  // ----------------------------------------

  assign i_in.ready = !full;
  assign wr_en      = i_in.valid && !full;
  assign wr_last    = wr_en && i_in.payload.last;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[MTU_LOG2-1:0]] <= i_in.payload;
    end
  end

  // ----------------------------------------
  // Read side
  // ----------------------------------------

  // Words are only offered while at least one whole packet is stored
  // This keeps a slowly built packet from holding an output of the fabric
  // Once offered, a packet drains one word per cycle without gaps, since
  // all of its words are already in the memory
  assign o_out.valid   = (pkt_cnt != '0);
  assign o_out.payload = mem[rd_ptr[MTU_LOG2-1:0]];
  assign rd_en         = o_out.valid && o_out.ready;
  assign rd_last       = rd_en && o_out.payload.last;

  // ----------------------------------------
  // Pointers and packet count
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      pkt_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // The count rises the cycle after a last word is written, so the first
      // word of a packet leaves no earlier than one cycle after its last word
      case ({wr_last, rd_last})
        2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
        2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
        default: pkt_cnt <= pkt_cnt;
      endcase
    end
  end

endmodule

//--- logic/small_fifo.sv
// ----------------------------------------
// Small first-word-fall-through FIFO for
// any payload type
// ----------------------------------------
`timescale 1ns/1ps

module small_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic       clk,
  input  logic       reset,
  xb_stream_if.snk   i_in,
  xb_stream_if.src   o_out
);

  // Storage and circular pointers
  T                           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       push;
  logic                       pop;

  // Ready depends only on the fill level, so a producer whose valid
  // follows ready cannot lock up against this FIFO
  assign i_in.ready = (count != $bits(count)'(DEPTH));
  assign push       = i_in.valid && i_in.ready;

  // The head entry is visible as soon as it is written
  assign o_out.valid   = (count != '0);
  assign o_out.payload = mem[rd_ptr];
  assign pop           = o_out.valid && o_out.ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_in.payload;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // Wrap at DEPTH so that non-power-of-two depths also work
        wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the level unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- logic/xb_stream_if.sv
// ----------------------------------------
// Valid/ready stream with a typed payload
// ----------------------------------------
`timescale 1ns/1ps

interface xb_stream_if #(
  parameter type T = logic
);

  // Payload of the current beat
  // Packet streams carry their end-of-packet bit inside the payload record
  T     payload;

  // A beat moves in a cycle where valid and ready are both high
  logic valid;
  logic ready;

  // The producer side drives payload and valid
  modport src (
    output payload,
    output valid,
    input  ready
  );

  // The consumer side drives ready only
  modport snk (
    input  payload,
    input  valid,
    output ready
  );

endinterface

//--- logic/xb_pkg.sv
// ----------------------------------------
// Crossbar ingress package with the shared
// sizes, routing codes and record types
// ----------------------------------------
package xb_pkg;

  // ----------------------------------------
  // Sizing
  // ----------------------------------------

  // Width of one packet word
  localparam int DATA_W = 64;

  // The packet buffer holds 2**MTU_LOG2 words, which is also the longest packet
  localparam int MTU_LOG2 = 5;

  // Width of an output port number, for four ports
  localparam int DEST_W = 2;

  // Port number of this node, the target of return-to-source packets
  localparam int NODE_ID = 1;

  // Width of an endpoint ID, taken from the low bits of the header
  localparam int EPID_W = 16;

  // Number of entries in the endpoint routing table
  localparam int RT_ENTRIES = 16;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [EPID_W-1:0] epid_t;
  typedef logic [DEST_W-1:0] port_t;

  // Routing code that travels with each packet
  // The unused fourth code is handled like ROUTE_TDEST
  typedef enum logic [1:0] {
    ROUTE_TDEST   = 2'd0,
    ROUTE_EPID    = 2'd1,
    RETURN_TO_SRC = 2'd2
  } route_e;

  // Destination of one packet; keep low tells the fabric to drop it
  typedef struct packed {
    port_t port;
    logic  keep;
  } dest_rec_t;

  // One packet word together with its end-of-packet marker
  typedef struct packed {
    word_t data;
    logic  last;
  } pkt_beat_t;

endpackage
